//--- mem_subsystem.f
rtl/mem_pkg.sv
rtl/sram_array.sv
rtl/axi_sram_slave.sv
rtl/axi_read_arbiter.sv
rtl/mem_subsystem.sv
sim/mem_subsystem_properties.sv
sim/mem_subsystem_tb.sv

//--- rtl/axi_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter (
    input  wire  logic           clk,
    input  wire  logic           rst_n,

    // instruction fetch master
    input  wire  mem_pkg::addr_t f_araddr,
    input  wire  logic           f_arvalid,
    output logic                 f_arready,
    output mem_pkg::data_t       f_rdata,
    output mem_pkg::resp_t       f_rresp,
    output logic                 f_rvalid,
    input  wire  logic           f_rready,

    // load/store master
    input  wire  mem_pkg::addr_t d_araddr,
    input  wire  logic           d_arvalid,
    output logic                 d_arready,
    output mem_pkg::data_t       d_rdata,
    output mem_pkg::resp_t       d_rresp,
    output logic                 d_rvalid,
    input  wire  logic           d_rready,

    // shared slave read channel
    output mem_pkg::addr_t       s_araddr,
    output logic                 s_arvalid,
    input  wire  logic           s_arready,
    input  wire  mem_pkg::data_t s_rdata,
    input  wire  mem_pkg::resp_t s_rresp,
    input  wire  logic           s_rvalid,
    output logic                 s_rready
);

    import mem_pkg::*;

    arb_state_t state;
    logic       gnt_data;
    logic       last_data;
    logic       pick_data;
    logic       sel_f;
    logic       sel_d;

    // data wins a tie only if fetch was served last
    assign pick_data = d_arvalid && (!f_arvalid || !last_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            gnt_data  <= 1'b0;
            last_data <= 1'b1;
        end else begin
            unique case (state)
                ARB_IDLE: begin
                    if (f_arvalid || d_arvalid) begin
                        gnt_data  <= pick_data;
                        last_data <= pick_data;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (s_rvalid && s_rready) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign sel_f = (state == ARB_BUSY) && !gnt_data;
    assign sel_d = (state == ARB_BUSY) && gnt_data;

    assign s_araddr  = gnt_data ? d_araddr : f_araddr;
    assign s_arvalid = (sel_f && f_arvalid) || (sel_d && d_arvalid);
    assign s_rready  = (sel_f && f_rready) || (sel_d && d_rready);

    assign f_arready = sel_f && s_arready;
    assign f_rvalid  = sel_f && s_rvalid;
    assign f_rdata   = sel_f ? s_rdata : '0;
    assign f_rresp   = sel_f ? s_rresp : RESP_OKAY;

    assign d_arready = sel_d && s_arready;
    assign d_rvalid  = sel_d && s_rvalid;
    assign d_rdata   = sel_d ? s_rdata : '0;
    assign d_rresp   = sel_d ? s_rresp : RESP_OKAY;

endmodule

`default_nettype wire

//--- rtl/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave (
    input  wire  logic               clk,
    input  wire  logic               rst_n,

    input  wire  mem_pkg::addr_t     araddr,
    input  wire  logic               arvalid,
    output logic                     arready,
    output mem_pkg::data_t           rdata,
    output mem_pkg::resp_t           rresp,
    output logic                     rvalid,
    input  wire  logic               rready,

    input  wire  mem_pkg::addr_t     awaddr,
    input  wire  logic               awvalid,
    output logic                     awready,
    input  wire  mem_pkg::data_t     wdata,
    input  wire  mem_pkg::strb_t     wstrb,
    input  wire  logic               wvalid,
    output logic                     wready,
    output mem_pkg::resp_t           bresp,
    output logic                     bvalid,
    input  wire  logic               bready,

    output logic                     rd_en,
    output mem_pkg::word_idx_t       rd_idx,
    input  wire  mem_pkg::data_t     rd_data,
    output logic                     wr_en,
    output mem_pkg::word_idx_t       wr_idx,
    output mem_pkg::data_t           wr_data,
    output mem_pkg::strb_t           wr_strb
);

    import mem_pkg::*;

    rd_state_t rd_state;
    lat_cnt_t  rd_cnt;
    addr_t     rd_addr;
    logic      rd_ok;

    wr_state_t wr_state;
    lat_cnt_t  wr_cnt;
    addr_t     wr_addr;
    logic      wr_ok;

    function automatic logic addr_in_window(addr_t a);
        return (a >= MEM_BASE) && (a < MEM_BASE + addr_t'(4 * MEM_WORDS));
    endfunction

    function automatic word_idx_t word_of(addr_t a);
        addr_t offset;
        offset = a - MEM_BASE;
        return word_idx_t'(offset >> 2);
    endfunction

    // array read issued on the last wait cycle, data lands with rvalid
    assign rd_idx = word_of(rd_addr);
    assign rd_en  = (rd_state == RD_WAIT) && (rd_cnt == lat_cnt_t'(ACCESS_LATENCY - 1)) && rd_ok;
    assign rdata  = rd_ok ? rd_data : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rresp    <= RESP_OKAY;
            rd_ok    <= 1'b0;
        end else begin
            unique case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        arready  <= 1'b1;
                        rd_state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arvalid && arready) begin
                        arready  <= 1'b0;
                        rd_addr  <= araddr;
                        rd_ok    <= addr_in_window(araddr);
                        rresp    <= addr_in_window(araddr) ? RESP_OKAY : RESP_SLVERR;
                        rd_cnt   <= '0;
                        rd_state <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (rd_cnt == lat_cnt_t'(ACCESS_LATENCY - 1)) begin
                        rvalid   <= 1'b1;
                        rd_state <= RD_RESP;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                RD_RESP: begin
                    if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // write lands in the array on the W handshake
    assign wr_idx  = word_of(wr_addr);
    assign wr_data = wdata;
    assign wr_strb = wstrb;
    assign wr_en   = (wr_state == WR_WAIT) && wready && wvalid && wr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            wr_ok    <= 1'b0;
        end else begin
            unique case (wr_state)
                WR_IDLE: begin
                    if (awvalid) begin
                        awready  <= 1'b1;
                        wr_state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awvalid && awready) begin
                        awready  <= 1'b0;
                        wr_addr  <= awaddr;
                        wr_ok    <= addr_in_window(awaddr);
                        bresp    <= addr_in_window(awaddr) ? RESP_OKAY : RESP_SLVERR;
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wvalid) begin
                        wr_cnt   <= '0;
                        wr_state <= WR_WAIT;
                    end
                end
                WR_WAIT: begin
                    if (wready && wvalid) begin
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= WR_RESP;
                    end else if (!wready) begin
                        if (wr_cnt == lat_cnt_t'(ACCESS_LATENCY - 1)) begin
                            wready <= 1'b1;
                        end else begin
                            wr_cnt <= wr_cnt + 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [7:0]  word_idx_t;

    // 1 KiB window at the start of the upper half of the map
    localparam addr_t MEM_BASE       = 32'h8000_0000;
    localparam int    MEM_WORDS      = 256;
    localparam int    ACCESS_LATENCY = 2;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef logic [$clog2(ACCESS_LATENCY + 1)-1:0] lat_cnt_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

`default_nettype wire

//--- rtl/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire  logic           clk,
    input  wire  logic           rst_n,

    input  wire  mem_pkg::addr_t f_araddr,
    input  wire  logic           f_arvalid,
    output wire  logic           f_arready,
    output wire  mem_pkg::data_t f_rdata,
    output wire  mem_pkg::resp_t f_rresp,
    output wire  logic           f_rvalid,
    input  wire  logic           f_rready,

    input  wire  mem_pkg::addr_t d_araddr,
    input  wire  logic           d_arvalid,
    output wire  logic           d_arready,
    output wire  mem_pkg::data_t d_rdata,
    output wire  mem_pkg::resp_t d_rresp,
    output wire  logic           d_rvalid,
    input  wire  logic           d_rready,

    input  wire  mem_pkg::addr_t d_awaddr,
    input  wire  logic           d_awvalid,
    output wire  logic           d_awready,
    input  wire  mem_pkg::data_t d_wdata,
    input  wire  mem_pkg::strb_t d_wstrb,
    input  wire  logic           d_wvalid,
    output wire  logic           d_wready,
    output wire  mem_pkg::resp_t d_bresp,
    output wire  logic           d_bvalid,
    input  wire  logic           d_bready
);

    import mem_pkg::*;

    // arbiter to slave read channel
    addr_t     s_araddr;
    logic      s_arvalid;
    logic      s_arready;
    data_t     s_rdata;
    resp_t     s_rresp;
    logic      s_rvalid;
    logic      s_rready;

    // slave to array
    logic      rd_en;
    word_idx_t rd_idx;
    data_t     rd_data;
    logic      wr_en;
    word_idx_t wr_idx;
    data_t     wr_data;
    strb_t     wr_strb;

    axi_read_arbiter i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .f_araddr  (f_araddr),
        .f_arvalid (f_arvalid),
        .f_arready (f_arready),
        .f_rdata   (f_rdata),
        .f_rresp   (f_rresp),
        .f_rvalid  (f_rvalid),
        .f_rready  (f_rready),
        .d_araddr  (d_araddr),
        .d_arvalid (d_arvalid),
        .d_arready (d_arready),
        .d_rdata   (d_rdata),
        .d_rresp   (d_rresp),
        .d_rvalid  (d_rvalid),
        .d_rready  (d_rready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    // write channels bypass the arbiter
    axi_sram_slave i_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (s_araddr),
        .arvalid (s_arvalid),
        .arready (s_arready),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .rvalid  (s_rvalid),
        .rready  (s_rready),
        .awaddr  (d_awaddr),
        .awvalid (d_awvalid),
        .awready (d_awready),
        .wdata   (d_wdata),
        .wstrb   (d_wstrb),
        .wvalid  (d_wvalid),
        .wready  (d_wready),
        .bresp   (d_bresp),
        .bvalid  (d_bvalid),
        .bready  (d_bready),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    sram_array i_array (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

endmodule

`default_nettype wire

//--- rtl/sram_array.sv
`timescale 1ns/1ps
`default_nettype none

module sram_array (
    input  wire  logic               clk,

    input  wire  logic               rd_en,
    input  wire  mem_pkg::word_idx_t rd_idx,
    output mem_pkg::data_t           rd_data,

    input  wire  logic               wr_en,
    input  wire  mem_pkg::word_idx_t wr_idx,
    input  wire  mem_pkg::data_t     wr_data,
    input  wire  mem_pkg::strb_t     wr_strb
);

    import mem_pkg::*;

    data_t mem [MEM_WORDS];

    // byte lanes follow the strobe bits
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // output register holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_subsystem_tb -f mem_subsystem.f \
    && { ./obj_dir/Vmem_subsystem_tb > sim.log 2>&1 || true; } \
    && ! grep -q "Testbench failed" sim.log \
    && grep -q "Testbench passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/mem_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_properties (
    input wire logic               clk,
    input wire logic               rst_n,
    input wire mem_pkg::addr_t     araddr,
    input wire logic               arvalid,
    input wire logic               arready,
    input wire mem_pkg::data_t     rdata,
    input wire mem_pkg::resp_t     rresp,
    input wire logic               rvalid,
    input wire logic               rready,
    input wire mem_pkg::data_t     wdata,
    input wire logic               wvalid,
    input wire logic               wready,
    input wire mem_pkg::resp_t     bresp,
    input wire logic               bvalid,
    input wire logic               bready,
    input wire logic               wr_en,
    input wire mem_pkg::wr_state_t wr_state
);

    import mem_pkg::*;

    // request side, as driven by the arbiter and the data master
    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before wready");

    // responses held through back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid, rdata or rresp changed before rready");

    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

    assert property (@(posedge clk) $rose(rst_n) |-> !rvalid && !bvalid)
        else $error("response valid right after reset");

    // array write is the last wait cycle, so the OKAY response follows
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |=> wr_state == WR_RESP && bvalid && bresp == RESP_OKAY)
        else $error("array write not followed by an OKAY write response");

endmodule

bind axi_sram_slave mem_subsystem_properties i_props (.*);

`default_nettype wire

//--- sim/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    import mem_pkg::*;

    typedef enum {PORT_F, PORT_D} port_e;
    typedef enum {OP_RD, OP_WR, OP_PAIR} kind_e;

    typedef struct {
        string name;
        port_e port;
        kind_e kind;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t exp_data;
        resp_t exp_resp;
    } op_t;

    logic  clk;
    logic  rst_n;
    addr_t f_araddr;
    logic  f_arvalid;
    logic  f_arready;
    data_t f_rdata;
    resp_t f_rresp;
    logic  f_rvalid;
    logic  f_rready;
    addr_t d_araddr;
    logic  d_arvalid;
    logic  d_arready;
    data_t d_rdata;
    resp_t d_rresp;
    logic  d_rvalid;
    logic  d_rready;
    addr_t d_awaddr;
    logic  d_awvalid;
    logic  d_awready;
    data_t d_wdata;
    strb_t d_wstrb;
    logic  d_wvalid;
    logic  d_wready;
    resp_t d_bresp;
    logic  d_bvalid;
    logic  d_bready;

    op_t         ops[$];
    bit          table_ready = 1'b0;
    int unsigned lcg_state;
    int          cycle = 0;
    // arbiter model, fetch is preferred after reset
    bit          last_was_data;

    mem_subsystem i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: data expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: resp expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // holds rready or bready low for 0 to 3 cycles
    task automatic stall_random();
        int n;
        n = int'(next_rand() % 4);
        repeat (n) next_cycle();
    endtask

    task automatic read_port(input port_e port, input addr_t a,
                             output data_t d, output resp_t r, output int seen);
        if (port == PORT_D) begin
            d_araddr  = a;
            d_arvalid = 1'b1;
            while (!d_arready) next_cycle();
            next_cycle();
            d_arvalid = 1'b0;
            while (!d_rvalid) next_cycle();
            seen = cycle;
            stall_random();
            d_rready = 1'b1;
            d = d_rdata;
            r = d_rresp;
            next_cycle();
            d_rready = 1'b0;
        end else begin
            f_araddr  = a;
            f_arvalid = 1'b1;
            while (!f_arready) next_cycle();
            next_cycle();
            f_arvalid = 1'b0;
            while (!f_rvalid) next_cycle();
            seen = cycle;
            stall_random();
            f_rready = 1'b1;
            d = f_rdata;
            r = f_rresp;
            next_cycle();
            f_rready = 1'b0;
        end
    endtask

    task automatic write_data(input addr_t a, input data_t w, input strb_t s, output resp_t r);
        d_awaddr  = a;
        d_awvalid = 1'b1;
        while (!d_awready) next_cycle();
        next_cycle();
        d_awvalid = 1'b0;
        d_wdata   = w;
        d_wstrb   = s;
        d_wvalid  = 1'b1;
        while (!d_wready) next_cycle();
        next_cycle();
        d_wvalid = 1'b0;
        while (!d_bvalid) next_cycle();
        stall_random();
        d_bready = 1'b1;
        r = d_bresp;
        next_cycle();
        d_bready = 1'b0;
    endtask

    task automatic run_op(input op_t op);
        data_t d;
        data_t d2;
        resp_t r;
        resp_t r2;
        int    f_seen;
        int    d_seen;
        port_e first;
        case (op.kind)
            OP_WR: begin
                write_data(op.addr, op.wdata, op.strb, r);
                check_resp(op.name, op.exp_resp, r);
            end
            OP_RD: begin
                read_port(op.port, op.addr, d, r, f_seen);
                check_data(op.name, op.exp_data, d);
                check_resp(op.name, op.exp_resp, r);
                last_was_data = (op.port == PORT_D);
            end
            default: begin
                // the master not granted last time goes first
                first = last_was_data ? PORT_F : PORT_D;
                fork
                    read_port(PORT_F, op.addr, d, r, f_seen);
                    read_port(PORT_D, op.addr, d2, r2, d_seen);
                join
                check_data(op.name, op.exp_data, d);
                check_resp(op.name, op.exp_resp, r);
                check_data(op.name, op.exp_data, d2);
                check_resp(op.name, op.exp_resp, r2);
                if ((first == PORT_F) != (f_seen < d_seen)) begin
                    stop_run($sformatf("%s: read responses came back in the wrong order",
                                       op.name));
                end
                last_was_data = (first == PORT_F);
            end
        endcase
    endtask

    task automatic add_op(input string name, input port_e port, input kind_e kind,
                          input addr_t addr, input data_t wdata, input strb_t strb,
                          input data_t exp_data, input resp_t exp_resp);
        op_t op;
        op = '{name, port, kind, addr, wdata, strb, exp_data, exp_resp};
        ops.push_back(op);
    endtask

    // writes only touch the slave, so the first pair still sees a fresh arbiter
    task automatic build_table();
        add_op("w_idx4",   PORT_D, OP_WR, MEM_BASE + 32'h10, 32'h0f1e_2d3c, 4'hf, '0, RESP_OKAY);
        add_op("w_idx8",   PORT_D, OP_WR, MEM_BASE + 32'h20, 32'h1357_9bdf, 4'hf, '0, RESP_OKAY);
        add_op("pair_1",   PORT_F, OP_PAIR, MEM_BASE + 32'h20, '0, '0, 32'h1357_9bdf, RESP_OKAY);
        add_op("w_full",   PORT_D, OP_WR, MEM_BASE + 32'h40, 32'hdead_beef, 4'hf, '0, RESP_OKAY);
        add_op("r_full",   PORT_D, OP_RD, MEM_BASE + 32'h40, '0, '0, 32'hdead_beef, RESP_OKAY);
        add_op("w_strb5",  PORT_D, OP_WR, MEM_BASE + 32'h40, 32'h1122_3344, 4'h5, '0, RESP_OKAY);
        add_op("r_merge",  PORT_D, OP_RD, MEM_BASE + 32'h40, '0, '0, 32'hde22_be44, RESP_OKAY);
        add_op("f_merge",  PORT_F, OP_RD, MEM_BASE + 32'h40, '0, '0, 32'hde22_be44, RESP_OKAY);
        add_op("pair_2",   PORT_F, OP_PAIR, MEM_BASE + 32'h10, '0, '0, 32'h0f1e_2d3c, RESP_OKAY);
        add_op("w_above",  PORT_D, OP_WR, MEM_BASE + 32'h410, 32'hbad0_bad0, 4'hf, '0, RESP_SLVERR);
        add_op("r_keep_a", PORT_D, OP_RD, MEM_BASE + 32'h10, '0, '0, 32'h0f1e_2d3c, RESP_OKAY);
        add_op("r_above",  PORT_D, OP_RD, MEM_BASE + 32'h400, '0, '0, '0, RESP_SLVERR);
        add_op("f_below",  PORT_F, OP_RD, 32'h7fff_fff0, '0, '0, '0, RESP_SLVERR);
        add_op("w_below",  PORT_D, OP_WR, 32'h7fff_fc10, 32'h55aa_55aa, 4'hf, '0, RESP_SLVERR);
        add_op("r_keep_b", PORT_D, OP_RD, MEM_BASE + 32'h10, '0, '0, 32'h0f1e_2d3c, RESP_OKAY);
        add_op("w_idx33",  PORT_D, OP_WR, MEM_BASE + 32'h84, 32'hcafe_f00d, 4'hf, '0, RESP_OKAY);
        add_op("f_idx33",  PORT_F, OP_RD, MEM_BASE + 32'h84, '0, '0, 32'hcafe_f00d, RESP_OKAY);
        add_op("w_strb2",  PORT_D, OP_WR, MEM_BASE + 32'h84, 32'h0000_aa00, 4'h2, '0, RESP_OKAY);
        add_op("r_strb2",  PORT_D, OP_RD, MEM_BASE + 32'h84, '0, '0, 32'hcafe_aa0d, RESP_OKAY);
    endtask

    initial begin
        rst_n     = 1'b0;
        f_araddr  = '0;
        f_arvalid = 1'b0;
        f_rready  = 1'b0;
        d_araddr  = '0;
        d_arvalid = 1'b0;
        d_rready  = 1'b0;
        d_awaddr  = '0;
        d_awvalid = 1'b0;
        d_wdata   = '0;
        d_wstrb   = '0;
        d_wvalid  = 1'b0;
        d_bready  = 1'b0;
        lcg_state = 17849;
        last_was_data = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        $display("Testbench passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat ((ops.size() + 4) * 64) @(posedge clk);
        stop_run("timeout: the operation table did not complete in time");
    end

endmodule

`default_nettype wire
